//--- design/backend_defines.svh
// Global sizing for the execute and write-back back end.
// Included by both packages and by every RTL module that sizes ports or arrays.
`ifndef BACKEND_DEFINES_SVH
`define BACKEND_DEFINES_SVH

// physical register file
`define NUM_PR   32   // number of physical registers
`define PR_IDX_W 5    // tag width, log2 of NUM_PR
`define ZERO_PR  31   // read-only zero register

// execution
`define NUM_FU   2    // functional units, one wait slot each
`define XLEN     64   // datapath width

`endif

//--- design/backend_types_pkg.sv
// Datapath types shared by the register file, units, arbiter and control.
// Covers tags, operand bundles, held unit results and the common data bus.
`default_nettype none

`include "backend_defines.svh"

package backend_types_pkg;

  typedef logic [`PR_IDX_W-1:0] pr_tag_t;  // physical register tag

  // common data bus broadcast, 70 bits
  typedef struct packed {
    logic             valid;    // one result this cycle
    pr_tag_t          T_idx;    // destination tag
    logic [`XLEN-1:0] T_value;  // result value
  } cdb_t;

  // source tags read by one unit
  typedef struct packed {
    pr_tag_t T1_idx;
    pr_tag_t T2_idx;
  } fu_tags_t;

  // operand values handed to one unit
  typedef struct packed {
    logic [`XLEN-1:0] T1_value;
    logic [`XLEN-1:0] T2_value;
  } fu_operands_t;

  // result held in a unit until granted
  typedef struct packed {
    logic             valid;  // waiting for the bus
    pr_tag_t          T_idx;
    logic [`XLEN-1:0] value;
  } fu_result_t;

endpackage

`default_nettype wire

//--- design/backend_ops_pkg.sv
// Operation-level types: ALU opcodes, wait slot states, the issue packet
// and the per-unit dispatch command.
`default_nettype none

`include "backend_defines.svh"

package backend_ops_pkg;
  import backend_types_pkg::*;

  typedef enum logic [2:0] {
    OP_LI, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL
  } alu_op_t;

  typedef enum logic [1:0] {
    SLOT_EMPTY,  // free, can accept
    SLOT_WAIT,   // waiting on sources
    SLOT_EXEC    // dispatched, result not yet on bus
  } slot_state_t;

  typedef struct packed {
    logic [$clog2(`NUM_FU)-1:0] fu_sel;  // target unit
    alu_op_t                    op;
    pr_tag_t                    T1_idx;
    pr_tag_t                    T2_idx;
    pr_tag_t                    T_idx;   // destination
    logic [15:0]                imm;
  } issue_pkt_t;

  typedef struct packed {
    logic        start;  // one-cycle dispatch
    alu_op_t     op;
    pr_tag_t     T_idx;
    logic [15:0] imm;
  } exec_cmd_t;

endpackage

`default_nettype wire

//--- design/phys_reg_file.sv
// Physical register file. Written once per cycle from the data bus and read
// combinationally for both operands of every unit, with same-cycle forwarding
// of the bus value. Register ZERO_PR is never written and reads as zero.
`timescale 1ns/10ps
`default_nettype none

`include "backend_defines.svh"

module phys_reg_file
  import backend_types_pkg::*;
(
  input  logic                       clock,
  input  logic                       reset,
  input  cdb_t                       cdb,       // write-back port
  input  fu_tags_t     [`NUM_FU-1:0] rd_tags,   // source tags per unit
  output fu_operands_t [`NUM_FU-1:0] operands   // values per unit
);

  logic [`NUM_PR-1:0][`XLEN-1:0] regs;
  logic                          wr_en;

  // bus value wins over stale storage
  function automatic logic [`XLEN-1:0] read_fwd(input pr_tag_t tag);
    if (cdb.valid && cdb.T_idx == tag && tag != pr_tag_t'(`ZERO_PR)) begin
      return cdb.T_value;  // forwarded
    end
    return regs[tag];
  endfunction

  assign wr_en = cdb.valid && (cdb.T_idx != pr_tag_t'(`ZERO_PR));  // zero reg is read-only

  always_ff @(posedge clock) begin
    if (reset) begin
      regs <= '0;  // all registers start at zero
    end else if (wr_en) begin
      regs[cdb.T_idx] <= cdb.T_value;
    end
  end

  // two read ports per unit
  always_comb begin
    for (int i = 0; i < `NUM_FU; i++) begin
      operands[i].T1_value = read_fwd(rd_tags[i].T1_idx);
      operands[i].T2_value = read_fwd(rd_tags[i].T2_idx);
    end
  end

  // a broadcast to ZERO_PR must never land in storage
  zero_reg_stays_zero: assert property (
    @(posedge clock) disable iff (reset)
    regs[`ZERO_PR] == '0
  ) else $error("zero register was written");

endmodule

`default_nettype wire

//--- design/alu_unit.sv
// One functional unit. A start pulse computes the op from the forwarded
// operands and registers tag and value at the same edge. The result stays
// valid and unchanged until the arbiter grants it onto the data bus.
`timescale 1ns/10ps
`default_nettype none

`include "backend_defines.svh"

module alu_unit
  import backend_types_pkg::*;
  import backend_ops_pkg::*;
(
  input  logic         clock,
  input  logic         reset,
  input  exec_cmd_t    cmd,       // dispatch from issue control
  input  fu_operands_t operands,  // from register file, same cycle
  input  logic         grant,     // result taken by the bus this cycle
  output fu_result_t   result
);

  logic [`XLEN-1:0] alu_out;
  logic             res_valid;
  pr_tag_t          res_tag;    // payload, loaded on start only
  logic [`XLEN-1:0] res_value;

  always_comb begin
    case (cmd.op)
      OP_LI:   alu_out = {{(`XLEN-16){cmd.imm[15]}}, cmd.imm};  // sign-extend imm
      OP_ADD:  alu_out = operands.T1_value + operands.T2_value;
      OP_SUB:  alu_out = operands.T1_value - operands.T2_value;
      OP_AND:  alu_out = operands.T1_value & operands.T2_value;
      OP_OR:   alu_out = operands.T1_value | operands.T2_value;
      OP_XOR:  alu_out = operands.T1_value ^ operands.T2_value;
      OP_SLL:  alu_out = operands.T1_value << operands.T2_value[5:0];  // low 6 bits
      default: alu_out = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      res_valid <= 1'b0;
    end else if (cmd.start) begin
      res_valid <= 1'b1;
    end else if (grant) begin
      res_valid <= 1'b0;  // left on the bus
    end
  end

  always_ff @(posedge clock) begin
    if (cmd.start) begin
      res_tag   <= cmd.T_idx;
      res_value <= alu_out;
    end
  end

  assign result = '{valid: res_valid, T_idx: res_tag, value: res_value};

  // control must hold back dispatch while this unit still owns a result
  no_start_when_busy: assert property (
    @(posedge clock) disable iff (reset)
    cmd.start |-> !res_valid
  ) else $error("start while previous result still held");

endmodule

`default_nettype wire

//--- design/cdb_arbiter.sv
// Common data bus arbiter. Picks one held unit result per cycle, lowest
// unit number first, and drives it onto the bus together with a one-hot
// grant back to that unit. Purely combinational.
`timescale 1ns/10ps
`default_nettype none

`include "backend_defines.svh"

module cdb_arbiter
  import backend_types_pkg::*;
(
  input  fu_result_t [`NUM_FU-1:0] results,
  output logic       [`NUM_FU-1:0] grant,
  output cdb_t                     cdb
);

  logic [`NUM_FU-1:0] valid_bits;

  always_comb begin
    for (int i = 0; i < `NUM_FU; i++) begin
      valid_bits[i] = results[i].valid;
    end
  end

  // walk down so the lowest valid unit is the last to claim the bus
  always_comb begin
    grant = '0;
    cdb   = '0;  // idle bus
    for (int i = `NUM_FU - 1; i >= 0; i--) begin
      if (valid_bits[i]) begin
        grant    = '0;
        grant[i] = 1'b1;
        cdb      = '{valid: 1'b1, T_idx: results[i].T_idx, T_value: results[i].value};
      end
    end
  end

  // at most one winner, and only ever a unit that holds a result
  grant_onehot_valid: assert final (
    $onehot0(grant) && ((grant & valid_bits) == grant) &&
    ((valid_bits == '0) || (grant != '0))
  ) else $error("bad data bus grant");

endmodule

`default_nettype wire

//--- design/issue_control.sv
// Issue and dispatch control. Tracks a ready bit per physical tag, holds one
// waiting op per unit and pulses start once both sources are ready (table or
// current bus) and the unit has no held result. A slot frees on its grant.
`timescale 1ns/10ps
`default_nettype none

`include "backend_defines.svh"

module issue_control
  import backend_types_pkg::*;
  import backend_ops_pkg::*;
(
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    issue_valid,  // one-cycle strobe
  input  issue_pkt_t              issue,
  output logic                    issue_ready,  // level, per selected unit
  input  cdb_t                    cdb,
  input  logic      [`NUM_FU-1:0] fu_busy,      // unit result valid
  input  logic      [`NUM_FU-1:0] grant,
  output exec_cmd_t [`NUM_FU-1:0] cmds,
  output fu_tags_t  [`NUM_FU-1:0] rd_tags
);

  logic        [`NUM_PR-1:0] pr_ready;    // tag holds its final value
  slot_state_t [`NUM_FU-1:0] slot_state;
  issue_pkt_t  [`NUM_FU-1:0] slot_pkt;    // waiting op, no reset
  logic        [`NUM_FU-1:0] start;
  logic                      accept;

  // ready now, counting this cycle's broadcast
  function automatic logic tag_ready(input pr_tag_t tag);
    return pr_ready[tag] || (cdb.valid && cdb.T_idx == tag);
  endfunction

  assign issue_ready = (slot_state[issue.fu_sel] == SLOT_EMPTY);
  assign accept      = issue_valid && issue_ready;

  always_comb begin
    for (int i = 0; i < `NUM_FU; i++) begin
      start[i] = (slot_state[i] == SLOT_WAIT) && !fu_busy[i] &&
                 ((slot_pkt[i].op == OP_LI) ||  // no sources
                  (tag_ready(slot_pkt[i].T1_idx) && tag_ready(slot_pkt[i].T2_idx)));
      cmds[i]    = '{start: start[i], op: slot_pkt[i].op,
                     T_idx: slot_pkt[i].T_idx, imm: slot_pkt[i].imm};
      rd_tags[i] = '{T1_idx: slot_pkt[i].T1_idx, T2_idx: slot_pkt[i].T2_idx};
    end
  end

  // slot FSM, one per unit
  always_ff @(posedge clock) begin
    for (int i = 0; i < `NUM_FU; i++) begin
      if (reset) begin
        slot_state[i] <= SLOT_EMPTY;
      end else begin
        case (slot_state[i])
          SLOT_EMPTY: if (accept && issue.fu_sel == i) slot_state[i] <= SLOT_WAIT;
          SLOT_WAIT:  if (start[i]) slot_state[i] <= SLOT_EXEC;
          SLOT_EXEC:  if (grant[i]) slot_state[i] <= SLOT_EMPTY;  // result left
          default:    slot_state[i] <= SLOT_EMPTY;
        endcase
      end
    end
  end

  always_ff @(posedge clock) begin
    for (int i = 0; i < `NUM_FU; i++) begin
      if (accept && issue.fu_sel == i) slot_pkt[i] <= issue;
    end
  end

  // newer issue overrides a same-cycle broadcast
  always_ff @(posedge clock) begin
    if (reset) begin
      pr_ready <= '1;
    end else begin
      if (cdb.valid) pr_ready[cdb.T_idx] <= 1'b1;
      if (accept && issue.T_idx != pr_tag_t'(`ZERO_PR)) pr_ready[issue.T_idx] <= 1'b0;
    end
  end

  // the issuing side must honour the ready level
  issue_respects_ready: assert property (
    @(posedge clock) disable iff (reset)
    issue_valid |-> issue_ready
  ) else $error("issue strobe while not ready");

endmodule

`default_nettype wire

//--- design/exec_backend_top.sv
// Top of the execute and write-back slice. Takes renamed ops on the issue
// strobe and reports every write-back on the common data bus output.
`timescale 1ns/10ps
`default_nettype none

`include "backend_defines.svh"

module exec_backend_top
  import backend_types_pkg::*;
  import backend_ops_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  logic       issue_valid,
  input  issue_pkt_t issue,
  output logic       issue_ready,
  output cdb_t       cdb          // write-back broadcast
);

  exec_cmd_t    [`NUM_FU-1:0] cmds;
  fu_tags_t     [`NUM_FU-1:0] rd_tags;
  fu_operands_t [`NUM_FU-1:0] operands;
  fu_result_t   [`NUM_FU-1:0] results;
  logic         [`NUM_FU-1:0] grant;
  logic         [`NUM_FU-1:0] fu_busy;   // held result per unit

  issue_control u_ctrl (
    .clock       (clock),
    .reset       (reset),
    .issue_valid (issue_valid),
    .issue       (issue),
    .issue_ready (issue_ready),
    .cdb         (cdb),
    .fu_busy     (fu_busy),
    .grant       (grant),
    .cmds        (cmds),
    .rd_tags     (rd_tags)
  );

  phys_reg_file u_prf (
    .clock    (clock),
    .reset    (reset),
    .cdb      (cdb),
    .rd_tags  (rd_tags),
    .operands (operands)
  );

  for (genvar i = 0; i < `NUM_FU; i++) begin : g_fu
    alu_unit u_alu (
      .clock    (clock),
      .reset    (reset),
      .cmd      (cmds[i]),
      .operands (operands[i]),
      .grant    (grant[i]),
      .result   (results[i])
    );
    assign fu_busy[i] = results[i].valid;
  end

  cdb_arbiter u_arb (
    .results (results),
    .grant   (grant),
    .cdb     (cdb)
  );

endmodule

`default_nettype wire

//--- testbench/tb_exec_backend.sv
// Testbench for the execute and write-back back end.
// Issues ops on the strobe interface and checks every data bus broadcast
// against a per-tag value model. Directed tests first, then a random run.
`timescale 1ns/10ps
`default_nettype none

`include "backend_defines.svh"

module tb_exec_backend
  import backend_types_pkg::*;
  import backend_ops_pkg::*;
();

  localparam int      NUM_OPS   = 8 + 8 + 2 + 3 + 200;  // issues over all tests
  localparam int      WD_CYCLES = 20 * NUM_OPS + 200;
  localparam pr_tag_t ZP        = pr_tag_t'(`ZERO_PR);

  logic       clock = 1'b0;
  logic       reset;
  logic       issue_valid;
  issue_pkt_t issue;
  logic       issue_ready;
  cdb_t       cdb;

  logic [`XLEN-1:0] expected   [`NUM_PR];                   // value each tag must broadcast
  int               issued_cnt [`NUM_PR];
  logic [`XLEN-1:0] seen_value [`NUM_PR] = '{default: '0};  // last broadcast per tag
  int               seen_cnt   [`NUM_PR] = '{default: 0};
  pr_tag_t          log_tag    [1024];                      // broadcast order
  pr_tag_t          fl_dst [`NUM_FU];                       // last op sent to each unit
  pr_tag_t          fl_src1 [`NUM_FU];
  pr_tag_t          fl_src2 [`NUM_FU];
  int               issue_count;
  int               chk_errors;
  int               bcast_count = 0;
  int               mon_errors = 0;
  logic [31:0]      lfsr;

  exec_backend_top UUT (
    .clock       (clock),
    .reset       (reset),
    .issue_valid (issue_valid),
    .issue       (issue),
    .issue_ready (issue_ready),
    .cdb         (cdb)
  );

  always #4 clock = ~clock;  // 8 ns period

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32 22 2 1
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};  // one step per bit
    end
    return v;
  endfunction

  function automatic logic in_flight(input pr_tag_t tag);
    return issued_cnt[tag] != seen_cnt[tag];
  endfunction

  function automatic logic [`XLEN-1:0] src_value(input pr_tag_t tag);
    return (tag == ZP) ? '0 : expected[tag];  // zero reg always reads 0
  endfunction

  function automatic logic [`XLEN-1:0] model_op(input alu_op_t op,
                                                input logic [`XLEN-1:0] a, b,
                                                input logic [15:0] imm);
    case (op)
      OP_LI:   return `XLEN'($signed(imm));
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_SLL:  return a << b[5:0];
      default: return '0;
    endcase
  endfunction

  // packet at 1 ns, strobe once ready has settled
  task automatic issue_op(input logic u, input alu_op_t op, input pr_tag_t s1, s2, d,
                          input logic [15:0] imm);
    issue = '{fu_sel: u, op: op, T1_idx: s1, T2_idx: s2, T_idx: d, imm: imm};
    #1;
    while (!issue_ready) begin
      @(posedge clock);
      #2;
    end
    expected[d]   = model_op(op, src_value(s1), src_value(s2), imm);
    issued_cnt[d] = issued_cnt[d] + 1;
    fl_dst[u]     = d;
    fl_src1[u]    = s1;
    fl_src2[u]    = s2;
    issue_count++;
    issue_valid = 1'b1;
    @(posedge clock);
    #1;
    issue_valid = 1'b0;
  endtask

  task automatic wait_idle();
    while (issue_count != bcast_count) begin
      @(posedge clock);
      #1;
    end
  endtask

  // data bus sampled mid-cycle, away from the edge
  always @(negedge clock) begin
    if (!reset && cdb.valid) begin
      if (!in_flight(cdb.T_idx)) begin
        $display("ERROR: at %0t tag %0d broadcast with no op in flight", $time, cdb.T_idx);
        mon_errors++;
      end else begin
        if (cdb.T_value !== expected[cdb.T_idx]) begin
          $display("MISMATCH at %0t: tag %0d broadcast %h, expected %h", $time,
                   cdb.T_idx, cdb.T_value, expected[cdb.T_idx]);
          mon_errors++;
        end
        seen_cnt[cdb.T_idx]++;
      end
      seen_value[cdb.T_idx]       = cdb.T_value;
      log_tag[bcast_count % 1024] = cdb.T_idx;
      bcast_count++;
    end
  end

  task automatic load_immediates();
    logic [15:0] imms [8] = '{16'h0001, 16'h7fff, 16'h8000, 16'hffff,
                              16'h1234, 16'hfedc, 16'h0040, 16'h0005};
    for (int t = 0; t < 8; t++) issue_op(t[0], OP_LI, ZP, ZP, pr_tag_t'(t), imms[t]);
    wait_idle();
    for (int t = 0; t < 8; t++) begin
      if (seen_value[t] !== `XLEN'($signed(imms[t]))) begin
        $display("MISMATCH at %0t: tag %0d not sign-extended imm", $time, t);
        chk_errors++;
      end
    end
  endtask

  // each op reads the one before, units alternate
  task automatic dependent_chain();
    alu_op_t ops [7] = '{OP_ADD, OP_SLL, OP_SUB, OP_XOR, OP_AND, OP_OR, OP_ADD};
    issue_op(1'b0, OP_LI, ZP, ZP, 5'd8, 16'd3);
    for (int k = 0; k < 7; k++) begin
      issue_op(~k[0], ops[k], pr_tag_t'(8 + k), pr_tag_t'(k), pr_tag_t'(9 + k), 16'h0);
    end
    wait_idle();
  endtask

  task automatic zero_register();
    issue_op(1'b1, OP_LI, ZP, ZP, ZP, 16'h5a5a);  // broadcasts, never stored
    issue_op(1'b0, OP_ADD, ZP, 5'd4, 5'd16, 16'h0);
    wait_idle();
    if (seen_value[16] !== `XLEN'(16'h1234)) begin  // tag 4 was loaded with 0x1234
      $display("MISMATCH at %0t: tag 31 did not read as zero", $time);
      chk_errors++;
    end
  endtask

  task automatic both_units();
    int first;
    first = bcast_count;
    issue_op(1'b0, OP_LI, ZP, ZP, 5'd20, 16'h0a0a);
    issue_op(1'b1, OP_LI, ZP, ZP, 5'd21, 16'hb0b0);  // back to back
    issue.fu_sel = 1'b0;  // probe unit 0 while busy
    #1;
    while (in_flight(5'd20)) begin
      if (issue_ready) begin
        $display("ERROR: at %0t issue_ready high for a busy unit 0", $time);
        chk_errors++;
      end
      @(posedge clock);
      #1;
    end
    if (!issue_ready) begin
      $display("ERROR: at %0t unit 0 still not ready after its result left", $time);
      chk_errors++;
    end
    issue_op(1'b0, OP_LI, ZP, ZP, 5'd22, 16'hc0c0);
    wait_idle();
    if (log_tag[first % 1024] != 5'd20 || log_tag[(first + 1) % 1024] != 5'd21 ||
        log_tag[(first + 2) % 1024] != 5'd22) begin
      $display("ERROR: at %0t results of both units out of order or repeated", $time);
      chk_errors++;
    end
  endtask

  // free of in-flight writes and of sources still to be read
  function automatic logic dest_free(input pr_tag_t d, s1, s2, input alu_op_t op);
    logic ok;
    ok = (d != ZP) && !in_flight(d) && (op == OP_LI || (d != s1 && d != s2));
    for (int i = 0; i < `NUM_FU; i++) begin
      if (in_flight(fl_dst[i]) && (d == fl_src1[i] || d == fl_src2[i])) ok = 1'b0;
    end
    return ok;
  endfunction

  task automatic random_sequence();
    logic        u;
    logic [31:0] r;
    alu_op_t     op;
    pr_tag_t     s1;
    pr_tag_t     s2;
    pr_tag_t     d;
    for (int n = 0; n < 200; n++) begin
      u  = 1'(rand_bits(1));
      r  = rand_bits(3);
      op = (r[2:0] == 3'd7) ? OP_ADD : alu_op_t'(r[2:0]);  // 7 is no opcode
      s1 = pr_tag_t'(rand_bits(5));
      s2 = pr_tag_t'(rand_bits(5));
      do begin
        d = pr_tag_t'(rand_bits(5));
      end while (!dest_free(d, s1, s2, op));
      issue_op(u, op, s1, s2, d, 16'(rand_bits(16)));
    end
    wait_idle();
  endtask

  initial begin
    lfsr        = 32'h31a5fe52;
    reset       = 1'b1;
    issue_valid = 1'b0;
    issue       = '0;
    issue_count = 0;
    chk_errors  = 0;
    for (int t = 0; t < `NUM_PR; t++) begin
      expected[t]   = '0;  // registers clear on reset
      issued_cnt[t] = 0;
    end
    for (int i = 0; i < `NUM_FU; i++) begin
      fl_dst[i]  = ZP;
      fl_src1[i] = ZP;
      fl_src2[i] = ZP;
    end
    repeat (5) @(posedge clock);
    #1;
    reset = 1'b0;
    if (!issue_ready) begin
      $display("ERROR: issue_ready low after reset");
      chk_errors++;
    end
    load_immediates();
    dependent_chain();
    zero_register();
    both_units();
    random_sequence();
    repeat (10) @(posedge clock);  // catch late extra broadcasts
    if (bcast_count != issue_count) begin
      $display("ERROR: %0d broadcasts for %0d issued ops", bcast_count, issue_count);
      chk_errors++;
    end
    $display("errors: %0d  broadcasts: %0d  issues: %0d", mon_errors + chk_errors,
             bcast_count, issue_count);
    if (mon_errors + chk_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (WD_CYCLES) @(posedge clock);
    $display("ERROR: timeout, run still busy after %0d cycles", WD_CYCLES);
    $display("errors: %0d  broadcasts: %0d  issues: %0d", mon_errors + chk_errors + 1,
             bcast_count, issue_count);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
+incdir+design
design/backend_types_pkg.sv
design/backend_ops_pkg.sv
design/phys_reg_file.sv
design/alu_unit.sv
design/cdb_arbiter.sv
design/issue_control.sv
design/exec_backend_top.sv
testbench/tb_exec_backend.sv

//--- Makefile
# Verilator build and run of the execute and write-back testbench
VERILATOR ?= verilator
TOP       ?= tb_exec_backend
RTL_TOP   ?= exec_backend_top
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing

SOURCES := $(wildcard design/*.sv design/*.svh testbench/*.sv)

.PHONY: all run build lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "run failed, see $(LOG)"; exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG) || { echo "no verdict in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
